// ==== src/jpegMarkerPkg.sv ====
// Marker code values and parser state encoding
`default_nettype none

package jpegMarkerPkg;

    // Two-byte marker codes that the parser acts on
    typedef enum logic [15:0] {
        soi  = 16'hFFD8,
        app0 = 16'hFFE0,
        dqt  = 16'hFFDB,
        dht  = 16'hFFC4,
        sof0 = 16'hFFC0,
        sos  = 16'hFFDA
    } markerCode;

    // --------------------
    // Parser states
    // --------------------
    typedef enum logic [4:0] {
        idle,
        getMarker,
        appLength,
        appRead,
        dqtLength,
        dqtTable,
        dqtRead,
        dhtLength,
        dhtTable,
        dhtCounts,
        dhtSymbols,
        sofLength,
        sofPrecision,
        sofHeight,
        sofWidth,
        sofComponents,
        sosLength,
        sosCount,
        sosComponents,
        sosTail0,
        sosTail1,
        sosTail2,
        imageData
    } parserState;

endpackage

`default_nettype wire

// ==== src/jpegTablePkg.sv ====
// Table index widths, Huffman value types and segment size constants
`default_nettype none

package jpegTablePkg;

    // Quantization entry index
    typedef logic [5:0] dqtIndex;

    // Bit 1 is the table id, bit 0 selects AC over DC
    typedef logic [1:0] dhtSelect;

    // Code length minus one
    typedef logic [3:0] huffLength;

    // First code of a length, left aligned
    typedef logic [15:0] huffCode;

    // Symbol index or running symbol total
    typedef logic [7:0] symbolCount;

    // --------------------
    // Segment sizes
    // --------------------
    localparam int dqtEntries = 64;

    // Three components at three bytes each
    localparam int sofComponentBytes = 9;

endpackage

`default_nettype wire

// ==== src/segmentSequencer.sv ====
// Marker decode and segment walking FSM with the segment byte counter
`timescale 1ns/1ps
`default_nettype none

module segmentSequencer (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            dataInEnable,
    input  wire [31:0]                     dataIn,
    input  wire                            countsDone,
    input  wire                            builderReady,
    input  wire                            symbolsDone,
    input  wire                            lastPixel,
    output jpegMarkerPkg::parserState      state,
    output logic                           dqtTable,
    output jpegTablePkg::dqtIndex          dqtCount,
    output jpegTablePkg::dhtSelect         dhtTable,
    output logic                           imageEnable,
    output logic                           idle
);

    logic [15:0] segCount;
    logic        wordTaken;

    // Huffman states only take a word once the builder is free
    assign wordTaken = dataInEnable &&
        ((state != jpegMarkerPkg::dhtCounts && state != jpegMarkerPkg::dhtSymbols) ||
         builderReady);

    assign idle     = (state == jpegMarkerPkg::idle);
    assign dqtCount = segCount[5:0];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= jpegMarkerPkg::idle;
            segCount    <= '0;
            dqtTable    <= 1'b0;
            dhtTable    <= '0;
            imageEnable <= 1'b0;
        end else if (state == jpegMarkerPkg::imageData) begin
            if (lastPixel) begin
                state       <= jpegMarkerPkg::idle;
                imageEnable <= 1'b0;
            end
        end else if (wordTaken) begin
            case (state)
                jpegMarkerPkg::idle: state <= jpegMarkerPkg::getMarker;

                jpegMarkerPkg::getMarker: begin
                    case (jpegMarkerPkg::markerCode'(dataIn[31:16]))
                        jpegMarkerPkg::soi:  state <= jpegMarkerPkg::getMarker;
                        jpegMarkerPkg::dqt:  state <= jpegMarkerPkg::dqtLength;
                        jpegMarkerPkg::dht:  state <= jpegMarkerPkg::dhtLength;
                        jpegMarkerPkg::sof0: state <= jpegMarkerPkg::sofLength;
                        jpegMarkerPkg::sos:  state <= jpegMarkerPkg::sosLength;
                        // APP0 and anything unknown are skipped by length
                        default:             state <= jpegMarkerPkg::appLength;
                    endcase
                end

                // --------------------
                // APP skip
                // --------------------
                jpegMarkerPkg::appLength: begin
                    segCount <= dataIn[31:16] - 16'd2;
                    state    <= jpegMarkerPkg::appRead;
                end
                jpegMarkerPkg::appRead: begin
                    if (segCount == 16'd1) begin
                        state <= jpegMarkerPkg::getMarker;
                    end
                    segCount <= segCount - 16'd1;
                end

                // --------------------
                // DQT
                // --------------------
                jpegMarkerPkg::dqtLength: state <= jpegMarkerPkg::dqtTable;
                jpegMarkerPkg::dqtTable: begin
                    dqtTable <= dataIn[24];
                    segCount <= '0;
                    state    <= jpegMarkerPkg::dqtRead;
                end
                jpegMarkerPkg::dqtRead: begin
                    if (segCount == 16'(jpegTablePkg::dqtEntries - 1)) begin
                        state <= jpegMarkerPkg::getMarker;
                    end
                    segCount <= segCount + 16'd1;
                end

                // --------------------
                // DHT
                // --------------------
                jpegMarkerPkg::dhtLength: state <= jpegMarkerPkg::dhtTable;
                jpegMarkerPkg::dhtTable: begin
                    // Low nibble is the id, high nibble the class
                    dhtTable <= {dataIn[24], dataIn[28]};
                    state    <= jpegMarkerPkg::dhtCounts;
                end
                jpegMarkerPkg::dhtCounts: begin
                    if (countsDone) begin
                        state <= jpegMarkerPkg::dhtSymbols;
                    end
                end
                jpegMarkerPkg::dhtSymbols: begin
                    if (symbolsDone) begin
                        state <= jpegMarkerPkg::getMarker;
                    end
                end

                // --------------------
                // SOF0
                // --------------------
                jpegMarkerPkg::sofLength:    state <= jpegMarkerPkg::sofPrecision;
                jpegMarkerPkg::sofPrecision: state <= jpegMarkerPkg::sofHeight;
                jpegMarkerPkg::sofHeight:    state <= jpegMarkerPkg::sofWidth;
                jpegMarkerPkg::sofWidth: begin
                    segCount <= '0;
                    state    <= jpegMarkerPkg::sofComponents;
                end
                jpegMarkerPkg::sofComponents: begin
                    if (segCount == 16'(jpegTablePkg::sofComponentBytes - 1)) begin
                        state <= jpegMarkerPkg::getMarker;
                    end
                    segCount <= segCount + 16'd1;
                end

                // --------------------
                // SOS
                // --------------------
                jpegMarkerPkg::sosLength: state <= jpegMarkerPkg::sosCount;
                jpegMarkerPkg::sosCount: begin
                    // Word holds Ns and the first selector byte
                    segCount <= {7'd0, dataIn[31:24], 1'b0} - 16'd1;
                    state    <= jpegMarkerPkg::sosComponents;
                end
                jpegMarkerPkg::sosComponents: begin
                    if (segCount == 16'd1) begin
                        state <= jpegMarkerPkg::sosTail0;
                    end
                    segCount <= segCount - 16'd1;
                end
                jpegMarkerPkg::sosTail0: state <= jpegMarkerPkg::sosTail1;
                jpegMarkerPkg::sosTail1: state <= jpegMarkerPkg::sosTail2;
                jpegMarkerPkg::sosTail2: begin
                    state       <= jpegMarkerPkg::imageData;
                    imageEnable <= 1'b1;
                end

                default: state <= jpegMarkerPkg::idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/huffmanCodeBuilder.sv ====
// Canonical Huffman first code and start index builder with symbol counter
`timescale 1ns/1ps
`default_nettype none

module huffmanCodeBuilder (
    input  wire                            clk,
    input  wire                            rst,
    input  wire jpegMarkerPkg::parserState state,
    input  wire                            dataInEnable,
    input  wire [31:0]                     dataIn,
    output logic                           builderReady,
    output logic                           countsDone,
    output logic                           symbolsDone,
    output logic                           huffmanEnable,
    output jpegTablePkg::huffLength        huffmanCount,
    output jpegTablePkg::huffCode          huffmanData,
    output jpegTablePkg::symbolCount       huffmanStart,
    output jpegTablePkg::symbolCount       dhtCount
);

    logic [15:0]              weight;
    jpegTablePkg::huffCode    runCode;
    jpegTablePkg::symbolCount runTotal;
    logic [7:0]               remaining;
    logic                     busy;
    logic                     takeCount;
    logic                     takeSymbol;

    assign builderReady = !busy;
    assign takeCount    = dataInEnable && !busy && (state == jpegMarkerPkg::dhtCounts);
    assign takeSymbol   = dataInEnable && !busy && (state == jpegMarkerPkg::dhtSymbols);

    // Sixteenth count byte is on offer
    assign countsDone    = (huffmanCount == 4'd15);
    assign huffmanEnable = busy && (remaining == 8'd0);
    assign symbolsDone   = ((dhtCount + 8'd1) == runTotal);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            weight       <= '0;
            runCode      <= '0;
            runTotal     <= '0;
            remaining    <= '0;
            busy         <= 1'b0;
            huffmanCount <= '0;
            huffmanData  <= '0;
            huffmanStart <= '0;
            dhtCount     <= '0;
        end else if (state == jpegMarkerPkg::dhtTable) begin
            // New table, weight starts at length 1
            weight       <= 16'h8000;
            runCode      <= '0;
            runTotal     <= '0;
            huffmanCount <= '0;
            dhtCount     <= '0;
        end else if (takeCount) begin
            busy         <= 1'b1;
            remaining    <= dataIn[31:24];
            huffmanData  <= runCode;
            huffmanStart <= runTotal;
            runTotal     <= runTotal + dataIn[31:24];
        end else if (busy) begin
            if (remaining != 8'd0) begin
                runCode   <= runCode + weight;
                remaining <= remaining - 8'd1;
            end else begin
                // Pulse cycle, move on to the next length
                busy         <= 1'b0;
                weight       <= weight >> 1;
                huffmanCount <= huffmanCount + 4'd1;
            end
        end else if (takeSymbol) begin
            dhtCount <= dhtCount + 8'd1;
        end
    end

endmodule

`default_nettype wire

// ==== src/frameGeometry.sv ====
// SOF0 size capture, MCU block width and last pixel detect
`timescale 1ns/1ps
`default_nettype none

module frameGeometry #(
    parameter int blockShift = 4
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire jpegMarkerPkg::parserState state,
    input  wire                            dataInEnable,
    input  wire [31:0]                     dataIn,
    input  wire                            outEnable,
    input  wire [15:0]                     outPixelX,
    input  wire [15:0]                     outPixelY,
    output logic [15:0]                    outWidth,
    output logic [15:0]                    outHeight,
    output logic [11:0]                    outBlockWidth,
    output logic                           lastPixel
);

    logic [16:0] roundedWidth;

    // Round width up to a whole block
    assign roundedWidth = {1'b0, dataIn[31:16]} + 17'((1 << blockShift) - 1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            outWidth      <= '0;
            outHeight     <= '0;
            outBlockWidth <= '0;
        end else if (dataInEnable) begin
            if (state == jpegMarkerPkg::sofHeight) begin
                outHeight <= dataIn[31:16];
            end
            if (state == jpegMarkerPkg::sofWidth) begin
                outWidth      <= dataIn[31:16];
                outBlockWidth <= 12'(roundedWidth >> blockShift);
            end
        end
    end

    assign lastPixel = outEnable &&
                       (outWidth == outPixelX + 16'd1) &&
                       (outHeight == outPixelY + 16'd1);

endmodule

`default_nettype wire

// ==== src/streamUseDecode.sv ====
// Aligner consumption strobes and table write strobes from the parser state
`timescale 1ns/1ps
`default_nettype none

module streamUseDecode (
    input  wire jpegMarkerPkg::parserState state,
    input  wire                            dataInEnable,
    input  wire                            builderReady,
    output logic                           useByte,
    output logic                           useWord,
    output logic                           dqtEnable,
    output logic                           dhtEnable
);

    logic byteState;
    logic wordState;

    always_comb begin
        byteState = 1'b0;
        wordState = 1'b0;
        case (state)
            jpegMarkerPkg::getMarker,
            jpegMarkerPkg::appLength,
            jpegMarkerPkg::dqtLength,
            jpegMarkerPkg::dhtLength,
            jpegMarkerPkg::sofLength,
            jpegMarkerPkg::sofHeight,
            jpegMarkerPkg::sofWidth,
            jpegMarkerPkg::sosLength,
            jpegMarkerPkg::sosCount:      wordState = 1'b1;
            jpegMarkerPkg::appRead,
            jpegMarkerPkg::dqtTable,
            jpegMarkerPkg::dqtRead,
            jpegMarkerPkg::dhtTable,
            jpegMarkerPkg::sofPrecision,
            jpegMarkerPkg::sofComponents,
            jpegMarkerPkg::sosComponents,
            jpegMarkerPkg::sosTail0,
            jpegMarkerPkg::sosTail1,
            jpegMarkerPkg::sosTail2:      byteState = 1'b1;
            // Hold off while the builder walks a length
            jpegMarkerPkg::dhtCounts,
            jpegMarkerPkg::dhtSymbols:    byteState = builderReady;
            default: begin
                byteState = 1'b0;
                wordState = 1'b0;
            end
        endcase
    end

    assign useByte   = dataInEnable && byteState;
    assign useWord   = dataInEnable && wordState;
    assign dqtEnable = dataInEnable && (state == jpegMarkerPkg::dqtRead);
    assign dhtEnable = dataInEnable && builderReady && (state == jpegMarkerPkg::dhtSymbols);

endmodule

`default_nettype wire

// ==== src/jpegHeaderParser.sv ====
// JPEG header parser top level wiring the decode, build and strobe stages
`timescale 1ns/1ps
`default_nettype none

module jpegHeaderParser #(
    parameter int blockShift = 4
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            dataInEnable,
    input  wire [31:0]                     dataIn,
    input  wire                            outEnable,
    input  wire [15:0]                     outPixelX,
    input  wire [15:0]                     outPixelY,
    output logic                           idle,
    output logic                           imageEnable,
    output logic [15:0]                    outWidth,
    output logic [15:0]                    outHeight,
    output logic [11:0]                    outBlockWidth,
    output logic                           dqtEnable,
    output logic                           dqtTable,
    output jpegTablePkg::dqtIndex          dqtCount,
    output logic [7:0]                     dqtData,
    output logic                           dhtEnable,
    output jpegTablePkg::dhtSelect         dhtTable,
    output jpegTablePkg::symbolCount       dhtCount,
    output logic [7:0]                     dhtData,
    output logic                           huffmanEnable,
    output jpegTablePkg::dhtSelect         huffmanTable,
    output jpegTablePkg::huffLength        huffmanCount,
    output jpegTablePkg::huffCode          huffmanData,
    output jpegTablePkg::symbolCount       huffmanStart,
    output logic                           useByte,
    output logic                           useWord
);

    jpegMarkerPkg::parserState state;
    logic                      countsDone;
    logic                      builderReady;
    logic                      symbolsDone;
    logic                      lastPixel;

    // Table payload is always the top byte
    assign dqtData      = dataIn[31:24];
    assign dhtData      = dataIn[31:24];
    assign huffmanTable = dhtTable;

    segmentSequencer u_sequencer (
        .clk          (clk),
        .rst          (rst),
        .dataInEnable (dataInEnable),
        .dataIn       (dataIn),
        .countsDone   (countsDone),
        .builderReady (builderReady),
        .symbolsDone  (symbolsDone),
        .lastPixel    (lastPixel),
        .state        (state),
        .dqtTable     (dqtTable),
        .dqtCount     (dqtCount),
        .dhtTable     (dhtTable),
        .imageEnable  (imageEnable),
        .idle         (idle)
    );

    huffmanCodeBuilder u_builder (
        .clk           (clk),
        .rst           (rst),
        .state         (state),
        .dataInEnable  (dataInEnable),
        .dataIn        (dataIn),
        .builderReady  (builderReady),
        .countsDone    (countsDone),
        .symbolsDone   (symbolsDone),
        .huffmanEnable (huffmanEnable),
        .huffmanCount  (huffmanCount),
        .huffmanData   (huffmanData),
        .huffmanStart  (huffmanStart),
        .dhtCount      (dhtCount)
    );

    frameGeometry #(
        .blockShift (blockShift)
    ) u_geometry (
        .clk           (clk),
        .rst           (rst),
        .state         (state),
        .dataInEnable  (dataInEnable),
        .dataIn        (dataIn),
        .outEnable     (outEnable),
        .outPixelX     (outPixelX),
        .outPixelY     (outPixelY),
        .outWidth      (outWidth),
        .outHeight     (outHeight),
        .outBlockWidth (outBlockWidth),
        .lastPixel     (lastPixel)
    );

    streamUseDecode u_useDecode (
        .state        (state),
        .dataInEnable (dataInEnable),
        .builderReady (builderReady),
        .useByte      (useByte),
        .useWord      (useWord),
        .dqtEnable    (dqtEnable),
        .dhtEnable    (dhtEnable)
    );

endmodule

`default_nettype wire

// ==== dv/jpegHeaderParser_properties.sv ====
// Bound concurrent assertions on the parser strobe outputs
`timescale 1ns/1ps
`default_nettype none

module jpegHeaderParserProperties (
    input wire clk,
    input wire rst,
    input wire dataInEnable,
    input wire useByte,
    input wire useWord,
    input wire dqtEnable,
    input wire dhtEnable,
    input wire huffmanEnable
);

    // Read by the testbench top
    int failCount = 0;

    // Aligner takes a byte or a word, never both
    useExclusive: assert property (@(posedge clk) disable iff (!rst) !(useByte && useWord))
        else begin
            failCount++;
            $error("useByte and useWord high in the same cycle");
        end

    strobeNeedsData: assert property (@(posedge clk) disable iff (!rst)
        (useByte || useWord || dqtEnable || dhtEnable) |-> dataInEnable)
        else begin
            failCount++;
            $error("Strobe high while dataInEnable is low");
        end

    // One pulse per code length
    huffmanSinglePulse: assert property (@(posedge clk) disable iff (!rst)
        huffmanEnable |=> !huffmanEnable)
        else begin
            failCount++;
            $error("huffmanEnable high in two consecutive cycles");
        end

endmodule

bind jpegHeaderParser jpegHeaderParserProperties u_properties (
    .clk           (clk),
    .rst           (rst),
    .dataInEnable  (dataInEnable),
    .useByte       (useByte),
    .useWord       (useWord),
    .dqtEnable     (dqtEnable),
    .dhtEnable     (dhtEnable),
    .huffmanEnable (huffmanEnable)
);

`default_nettype wire

// ==== dv/tbJpegHeaderParser.sv ====
// Testbench with stream driving tasks, directed tests, value checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module tbJpegHeaderParser;

    localparam int blockShift   = 4;
    localparam int blockEdge    = 1 << blockShift;
    localparam int maxTestWords = 128;
    localparam int numTests     = 6;
    localparam int wordCycles   = 20;
    localparam int frameWidth   = 100;
    localparam int frameHeight  = 37;

    // Marker codes from the JPEG standard
    localparam logic [15:0] markSoi  = 16'hFFD8;
    localparam logic [15:0] markApp0 = 16'hFFE0;
    localparam logic [15:0] markDqt  = 16'hFFDB;
    localparam logic [15:0] markDht  = 16'hFFC4;
    localparam logic [15:0] markSof0 = 16'hFFC0;
    localparam logic [15:0] markSos  = 16'hFFDA;

    logic        clk;
    logic        rst;
    logic        dataInEnable;
    logic [31:0] dataIn;
    logic        outEnable;
    logic [15:0] outPixelX;
    logic [15:0] outPixelY;
    logic        idle;
    logic        imageEnable;
    logic [15:0] outWidth;
    logic [15:0] outHeight;
    logic [11:0] outBlockWidth;
    logic        dqtEnable;
    logic        dqtTable;
    logic [5:0]  dqtCount;
    logic [7:0]  dqtData;
    logic        dhtEnable;
    logic [1:0]  dhtTable;
    logic [7:0]  dhtCount;
    logic [7:0]  dhtData;
    logic        huffmanEnable;
    logic [1:0]  huffmanTable;
    logic [3:0]  huffmanCount;
    logic [15:0] huffmanData;
    logic [7:0]  huffmanStart;
    logic        useByte;
    logic        useWord;

    logic [31:0] randState = 32'h59e3;
    string       testName  = "none";
    logic [3:0]  huffIndexQ[$];
    logic [15:0] huffCodeQ[$];
    logic [7:0]  huffStartQ[$];
    logic [1:0]  huffTableQ[$];

    jpegHeaderParser #(
        .blockShift (blockShift)
    ) i_dut (
        .clk           (clk),
        .rst           (rst),
        .dataInEnable  (dataInEnable),
        .dataIn        (dataIn),
        .outEnable     (outEnable),
        .outPixelX     (outPixelX),
        .outPixelY     (outPixelY),
        .idle          (idle),
        .imageEnable   (imageEnable),
        .outWidth      (outWidth),
        .outHeight     (outHeight),
        .outBlockWidth (outBlockWidth),
        .dqtEnable     (dqtEnable),
        .dqtTable      (dqtTable),
        .dqtCount      (dqtCount),
        .dqtData       (dqtData),
        .dhtEnable     (dhtEnable),
        .dhtTable      (dhtTable),
        .dhtCount      (dhtCount),
        .dhtData       (dhtData),
        .huffmanEnable (huffmanEnable),
        .huffmanTable  (huffmanTable),
        .huffmanCount  (huffmanCount),
        .huffmanData   (huffmanData),
        .huffmanStart  (huffmanStart),
        .useByte       (useByte),
        .useWord       (useWord)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRandom();
        randState = xorshift(randState);
        return randState;
    endfunction

    task automatic checkValue(input string field, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s expected %0h actual %0h", testName, field, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Returns in the cycle the aligner sees a use strobe
    task automatic presentWord(input logic [31:0] word, input logic isWord);
        string label;
        label = isWord ? "useWord" : "useByte";
        @(posedge clk);
        if (nextRandom() % 8 == 0) begin
            dataInEnable <= 1'b0;
            @(posedge clk);
        end
        dataIn       <= word;
        dataInEnable <= 1'b1;
        @(negedge clk);
        while (!(useByte || useWord)) begin
            @(negedge clk);
        end
        checkValue(label, 1'b1, isWord ? useWord : useByte);
    endtask

    task automatic sendWord(input logic [15:0] value);
        presentWord({value, 16'h0000}, 1'b1);
    endtask

    task automatic sendByte(input logic [7:0] value);
        presentWord({value, 24'h000000}, 1'b0);
    endtask

    task automatic releaseBus();
        @(posedge clk);
        dataInEnable <= 1'b0;
    endtask

    task automatic drivePixel(input logic [15:0] x, input logic [15:0] y);
        @(posedge clk);
        outEnable <= 1'b1;
        outPixelX <= x;
        outPixelY <= y;
        @(posedge clk);
        outEnable <= 1'b0;
        @(negedge clk);
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic testReset();
        testName = "reset";
        @(negedge clk);
        checkValue("idle", 1'b1, idle);
        checkValue("imageEnable", 1'b0, imageEnable);
        checkValue("strobes", 0, {useByte, useWord, dqtEnable, dhtEnable, huffmanEnable});
        checkValue("outWidth", 0, outWidth);
        checkValue("outHeight", 0, outHeight);
        checkValue("outBlockWidth", 0, outBlockWidth);
        sendWord(markSoi);
        checkValue("idle", 1'b0, idle);
    endtask

    task automatic testSkip();
        int appBytes;
        int i;
        testName = "skip";
        appBytes = 1 + int'(nextRandom() % 16);
        sendWord(markSoi);
        sendWord(markApp0);
        sendWord(16'(appBytes + 2));
        for (i = 0; i < appBytes; i++) begin
            sendByte(8'(nextRandom()));
        end
        // COM marker is unknown to the parser
        sendWord(16'hFFFE);
        sendWord(16'd5);
        for (i = 0; i < 3; i++) begin
            sendByte(8'(nextRandom()));
        end
    endtask

    task automatic testDqt(input logic sel);
        logic [7:0] entry;
        int         i;
        testName = "dqt";
        sendWord(markDqt);
        sendWord(16'd67);
        sendByte({7'd0, sel});
        for (i = 0; i < 64; i++) begin
            entry = 8'(nextRandom());
            sendByte(entry);
            checkValue("dqtEnable", 1'b1, dqtEnable);
            checkValue("dqtCount", i, dqtCount);
            checkValue("dqtData", entry, dqtData);
            checkValue("dqtTable", sel, dqtTable);
        end
    endtask

    task automatic testDht();
        logic [7:0]  counts [16];
        logic [7:0]  symbol;
        logic [31:0] expCode;
        int          expStart;
        int          total;
        int          i;
        testName = "dht";
        huffIndexQ.delete();
        huffCodeQ.delete();
        huffStartQ.delete();
        huffTableQ.delete();
        // Small counts that still form a valid code set
        total = 0;
        for (i = 0; i < 16; i++) begin
            if (i == 0) counts[i] = 8'd0;
            else if (i == 1) counts[i] = 8'(1 + nextRandom() % 2);
            else counts[i] = 8'(nextRandom() % 3);
            total += counts[i];
        end
        sendWord(markDht);
        sendWord(16'(19 + total));
        // DC class, table id 1
        sendByte(8'h01);
        for (i = 0; i < 16; i++) begin
            sendByte(counts[i]);
        end
        for (i = 0; i < total; i++) begin
            symbol = 8'(nextRandom());
            sendByte(symbol);
            checkValue("dhtEnable", 1'b1, dhtEnable);
            checkValue("dhtCount", i, dhtCount);
            checkValue("dhtData", symbol, dhtData);
            checkValue("dhtTable", 2'b10, dhtTable);
        end
        checkValue("huffmanPulses", 16, huffIndexQ.size());
        expCode  = 0;
        expStart = 0;
        for (i = 0; i < 16; i++) begin
            checkValue("huffmanCount", i, huffIndexQ[i]);
            checkValue("huffmanData", expCode, huffCodeQ[i]);
            checkValue("huffmanStart", expStart, huffStartQ[i]);
            checkValue("huffmanTable", 2'b10, huffTableQ[i]);
            expCode  = expCode + (32'(counts[i]) << (15 - i));
            expStart = expStart + counts[i];
        end
    endtask

    task automatic testFrame();
        int i;
        testName = "frame";
        sendWord(markSof0);
        sendWord(16'd17);
        sendByte(8'd8);
        sendWord(16'(frameHeight));
        sendWord(16'(frameWidth));
        for (i = 0; i < 9; i++) begin
            sendByte(8'(nextRandom()));
        end
        checkValue("outWidth", frameWidth, outWidth);
        checkValue("outHeight", frameHeight, outHeight);
        // Whole blocks plus one for a partial block
        checkValue("outBlockWidth",
                   frameWidth / blockEdge + int'(frameWidth % blockEdge != 0),
                   outBlockWidth);
        sendWord(markSos);
        sendWord(16'd12);
        sendWord({8'd3, 8'd1});
        for (i = 0; i < 5; i++) begin
            sendByte(8'(nextRandom()));
        end
        sendByte(8'h00);
        sendByte(8'h3F);
        sendByte(8'h00);
        checkValue("imageEnable", 1'b0, imageEnable);
        releaseBus();
        @(negedge clk);
        checkValue("imageEnable", 1'b1, imageEnable);
        drivePixel(16'd0, 16'd0);
        drivePixel(16'(frameWidth - 1), 16'd0);
        drivePixel(16'd0, 16'(frameHeight - 1));
        drivePixel(16'(frameWidth - 2), 16'(frameHeight - 1));
        checkValue("imageEnable", 1'b1, imageEnable);
        drivePixel(16'(frameWidth - 1), 16'(frameHeight - 1));
        checkValue("imageEnable", 1'b0, imageEnable);
        checkValue("idle", 1'b1, idle);
    endtask

    // Collect one entry per Huffman pulse
    always @(negedge clk) begin
        if (rst && huffmanEnable) begin
            huffIndexQ.push_back(huffmanCount);
            huffCodeQ.push_back(huffmanData);
            huffStartQ.push_back(huffmanStart);
            huffTableQ.push_back(huffmanTable);
        end
    end

    // Bound assertions count their failures
    always @(negedge clk) begin
        if (i_dut.u_properties.failCount != 0) begin
            $display("A strobe assertion on the DUT failed");
            $display("ERRORS FOUND");
            $fatal(1, "Assertion failure");
        end
    end

    initial begin
        repeat (numTests * maxTestWords * wordCycles) @(posedge clk);
        $display("Timeout: the parser hung and stopped taking stream words");
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        rst          = 1'b0;
        dataInEnable = 1'b0;
        dataIn       = '0;
        outEnable    = 1'b0;
        outPixelX    = '0;
        outPixelY    = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        testReset();
        testSkip();
        testDqt(1'b0);
        testDht();
        testDqt(1'b1);
        testFrame();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
src/jpegMarkerPkg.sv
src/jpegTablePkg.sv
src/segmentSequencer.sv
src/huffmanCodeBuilder.sv
src/frameGeometry.sv
src/streamUseDecode.sv
src/jpegHeaderParser.sv
dv/jpegHeaderParser_properties.sv
dv/tbJpegHeaderParser.sv
